/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ns
TOP       = tb_tiny86
FILELIST  = all.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# A $$fatal in the testbench gives a nonzero exit status.
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* all.f */
design/x86_arch_pkg.sv
design/trace_pkg.sv
design/step_fetch.sv
design/hint_decode.sv
design/instr_decode.sv
design/alu_execute.sv
design/reg_writeback.sv
design/tiny86.sv
verification/clock_gen.sv
verification/tb_tiny86.sv

/* design/alu_execute.sv */
`timescale 1ns/1ns
`default_nettype none

module alu_execute (
  input  wire x86_arch_pkg::arch_state_t i_pre,
  input  wire trace_pkg::uop_t           i_uop,
  output x86_arch_pkg::arch_state_t      o_post
);

  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] result;
  logic [31:0] seq_eip;
  logic        carry;
  logic        set_zs;

  assign a       = i_uop.a_val;
  assign b       = i_uop.b_val;
  assign seq_eip = i_pre.eip + {28'd0, i_uop.len};

  always_comb begin
    o_post = i_pre;
    result = b;
    carry  = 1'b0;
    set_zs = 1'b0;
    case (i_uop.op)
      trace_pkg::ADD: begin
        {carry, result} = {1'b0, a} + {1'b0, b};
        o_post.eflags[x86_arch_pkg::FLAG_CF] = carry;
        o_post.eflags[x86_arch_pkg::FLAG_OF] = (a[31] == b[31]) && (result[31] != a[31]);
        set_zs = 1'b1;
      end
      trace_pkg::SUB: begin
        // Carry out of the 33-bit difference is the borrow.
        {carry, result} = {1'b0, a} - {1'b0, b};
        o_post.eflags[x86_arch_pkg::FLAG_CF] = carry;
        o_post.eflags[x86_arch_pkg::FLAG_OF] = (a[31] != b[31]) && (result[31] != a[31]);
        set_zs = 1'b1;
      end
      trace_pkg::XOR: begin
        result = a ^ b;
        o_post.eflags[x86_arch_pkg::FLAG_CF] = 1'b0;
        o_post.eflags[x86_arch_pkg::FLAG_OF] = 1'b0;
        set_zs = 1'b1;
      end
      trace_pkg::INC: begin
        result = a + 32'd1;
        o_post.eflags[x86_arch_pkg::FLAG_OF] = (a == 32'h7FFF_FFFF);
        set_zs = 1'b1;
      end
      trace_pkg::DEC: begin
        result = a - 32'd1;
        o_post.eflags[x86_arch_pkg::FLAG_OF] = (a == 32'h8000_0000);
        set_zs = 1'b1;
      end
      default: begin
        result = b;
      end
    endcase

    if (set_zs) begin
      o_post.eflags[x86_arch_pkg::FLAG_ZF] = (result == 32'd0);
      o_post.eflags[x86_arch_pkg::FLAG_SF] = result[31];
    end

    if (i_uop.write_dst) begin
      o_post.gpr[i_uop.dst] = result;
    end

    // For jcxz, a_val holds ecx.
    case (i_uop.op)
      trace_pkg::JMP:  o_post.eip = seq_eip + i_uop.rel;
      trace_pkg::JCXZ: o_post.eip = (a == 32'd0) ? seq_eip + i_uop.rel : seq_eip;
      default:         o_post.eip = seq_eip;
    endcase
  end

endmodule

`default_nettype wire

/* design/hint_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module hint_decode (
  input  wire trace_pkg::raw_hint_t i_raw,
  output trace_pkg::hint_t          o_hint
);

  logic [3:0] byte_en;

  always_comb begin
    case (i_raw.mask)
      trace_pkg::MASK_BYTE:  byte_en = 4'b0001;
      trace_pkg::MASK_WORD:  byte_en = 4'b0011;
      trace_pkg::MASK_DWORD: byte_en = 4'b1111;
      default:               byte_en = 4'b0000;
    endcase
  end

  always_comb begin
    o_hint.is_write = i_raw.is_write;
    o_hint.byte_en  = byte_en;
    o_hint.address  = i_raw.address;
    o_hint.data     = i_raw.data;
    // Reserved bits set or an unknown size make the hint unusable.
    o_hint.valid    = i_raw.valid && (i_raw.reserved == 4'd0) && (byte_en != 4'b0000);
  end

endmodule

`default_nettype wire

/* design/instr_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module instr_decode (
  input  wire trace_pkg::trace_step_t i_step,
  input  wire trace_pkg::hint_t       i_hint1,
  output trace_pkg::uop_t             o_uop,
  output trace_pkg::fault_t           o_fault
);

  logic [7:0]             opc;
  logic [1:0]             modrm_mod;
  x86_arch_pkg::reg_idx_t modrm_reg;
  x86_arch_pkg::reg_idx_t modrm_rm;
  logic [31:0]            rm_val;
  logic [31:0]            reg_val;
  logic                   mem_form;
  logic                   store_hint_ok;
  logic                   load_hint_ok;

  assign opc       = i_step.instr[0];
  assign modrm_mod = i_step.instr[1][7:6];
  assign modrm_reg = i_step.instr[1][5:3];
  assign modrm_rm  = i_step.instr[1][2:0];
  assign rm_val    = i_step.pre.gpr[modrm_rm];
  assign reg_val   = i_step.pre.gpr[modrm_reg];

  // Plain [reg] only. rm=esp needs SIB, rm=ebp means disp32.
  assign mem_form = (modrm_mod == trace_pkg::MOD_IND) &&
                    (modrm_rm != x86_arch_pkg::REG_ESP) &&
                    (modrm_rm != x86_arch_pkg::REG_EBP);

  assign store_hint_ok = i_hint1.valid && i_hint1.is_write && (i_hint1.byte_en == 4'hF) &&
                         (i_hint1.address == rm_val) && (i_hint1.data == reg_val);
  assign load_hint_ok  = i_hint1.valid && !i_hint1.is_write && (i_hint1.byte_en == 4'hF) &&
                         (i_hint1.address == rm_val);

  always_comb begin
    o_uop     = '0;
    o_uop.op  = trace_pkg::NOP;
    o_uop.rel = {{24{i_step.instr[1][7]}}, i_step.instr[1]};
    o_fault   = '0;
    case (opc)
      trace_pkg::OPC_NOP: o_uop.len = 4'd1;
      trace_pkg::OPC_ADD, trace_pkg::OPC_SUB, trace_pkg::OPC_XOR: begin
        if (modrm_mod == trace_pkg::MOD_REG) begin
          o_uop.op        = (opc == trace_pkg::OPC_ADD) ? trace_pkg::ADD :
                            (opc == trace_pkg::OPC_SUB) ? trace_pkg::SUB : trace_pkg::XOR;
          o_uop.dst       = modrm_rm;
          o_uop.a_val     = rm_val;
          o_uop.b_val     = reg_val;
          o_uop.write_dst = 1'b1;
          o_uop.len       = 4'd2;
        end else begin
          o_fault.bad_opcode = 1'b1;
        end
      end
      trace_pkg::OPC_MOV_ST: begin
        o_uop.a_val = rm_val;
        o_uop.b_val = reg_val;
        o_uop.len   = 4'd2;
        if (modrm_mod == trace_pkg::MOD_REG) begin
          o_uop.op        = trace_pkg::MOV;
          o_uop.dst       = modrm_rm;
          o_uop.write_dst = 1'b1;
        end else if (mem_form) begin
          o_uop.op         = trace_pkg::STORE;
          o_fault.bad_hint = !store_hint_ok;
        end else begin
          o_fault.bad_opcode = 1'b1;
        end
      end
      trace_pkg::OPC_MOV_LD: begin
        if (mem_form) begin
          // Memory data comes from the tracer's hint.
          o_uop.op         = trace_pkg::LOAD;
          o_uop.dst        = modrm_reg;
          o_uop.a_val      = rm_val;
          o_uop.b_val      = i_hint1.data;
          o_uop.write_dst  = 1'b1;
          o_uop.len        = 4'd2;
          o_fault.bad_hint = !load_hint_ok;
        end else begin
          o_fault.bad_opcode = 1'b1;
        end
      end
      trace_pkg::OPC_JMP: begin
        o_uop.op  = trace_pkg::JMP;
        o_uop.len = 4'd2;
      end
      trace_pkg::OPC_JCXZ: begin
        o_uop.op    = trace_pkg::JCXZ;
        o_uop.a_val = i_step.pre.gpr[x86_arch_pkg::REG_ECX];
        o_uop.len   = 4'd2;
      end
      default: begin
        // inc and dec carry the register in the low three opcode bits.
        o_uop.dst       = opc[2:0];
        o_uop.a_val     = i_step.pre.gpr[opc[2:0]];
        o_uop.write_dst = 1'b1;
        o_uop.len       = 4'd1;
        if ({opc[7:3], 3'b000} == trace_pkg::OPC_INC) begin
          o_uop.op = trace_pkg::INC;
        end else if ({opc[7:3], 3'b000} == trace_pkg::OPC_DEC) begin
          o_uop.op = trace_pkg::DEC;
        end else begin
          o_uop.write_dst    = 1'b0;
          o_uop.len          = 4'd0;
          o_fault.bad_opcode = 1'b1;
        end
      end
    endcase
  end

endmodule

`default_nettype wire

/* design/reg_writeback.sv */
`timescale 1ns/1ns
`default_nettype none

module reg_writeback (
  input  wire logic                      i_clk,
  input  wire logic                      i_rst_n,
  input  wire logic                      i_commit,
  input  wire x86_arch_pkg::arch_state_t i_pre,
  input  wire x86_arch_pkg::arch_state_t i_post,
  input  wire trace_pkg::fault_t         i_fault,
  output x86_arch_pkg::arch_state_t      o_state,
  output trace_pkg::fault_t              o_fault
);

  logic any_fault;

  assign any_fault = i_fault.bad_opcode || i_fault.bad_hint;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      o_state <= '0;
      o_fault <= '0;
    end else if (i_commit) begin
      // A faulting step leaves the pre-state in place.
      o_state <= any_fault ? i_pre : i_post;
      o_fault <= i_fault;
    end
  end

  state_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    !i_commit |=> $stable(o_state))
    else $error("o_state changed without a commit");

endmodule

`default_nettype wire

/* design/step_fetch.sv */
`timescale 1ns/1ns
`default_nettype none

module step_fetch (
  input  wire logic                   i_clk,
  input  wire logic                   i_rst_n,
  input  wire logic                   i_req,
  input  wire trace_pkg::trace_step_t i_step,
  output trace_pkg::trace_step_t      o_step,
  output logic                        o_commit,
  output logic                        o_ack
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_COMMIT,
    S_ACK
  } state_e;

  state_e state;

  always_ff @(posedge i_clk) begin
    if (!i_rst_n) begin
      state <= S_IDLE;
      o_ack <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (i_req) begin
            state <= S_COMMIT;
          end
        end
        S_COMMIT: begin
          state <= S_ACK;
        end
        S_ACK: begin
          // Ack one cycle after commit, then wait for the source to drop req.
          if (!o_ack) begin
            o_ack <= 1'b1;
          end else if (!i_req) begin
            o_ack <= 1'b0;
            state <= S_IDLE;
          end
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  // Step capture, only on an accepted request.
  always_ff @(posedge i_clk) begin
    if (state == S_IDLE && i_req) begin
      o_step <= i_step;
    end
  end

  assign o_commit = (state == S_COMMIT);

  ack_after_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    $rose(o_ack) |-> $past(i_req))
    else $error("o_ack rose without a pending request");

  commit_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    o_commit |=> !o_commit)
    else $error("commit pulse longer than one cycle");

endmodule

`default_nettype wire

/* design/tiny86.sv */
`timescale 1ns/1ns
`default_nettype none

module tiny86 (
  input  wire logic                   i_clk,
  input  wire logic                   i_rst_n,
  input  wire logic                   i_req,
  input  wire trace_pkg::trace_step_t i_step,
  output logic                        o_ack,
  output x86_arch_pkg::arch_state_t   o_state,
  output trace_pkg::fault_t           o_fault
);

  trace_pkg::trace_step_t    step;
  logic                      commit;
  trace_pkg::hint_t          hint1;
  trace_pkg::uop_t           uop;
  trace_pkg::fault_t         dec_fault;
  x86_arch_pkg::arch_state_t post;

  step_fetch u_fetch (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_req    (i_req),
    .i_step   (i_step),
    .o_step   (step),
    .o_commit (commit),
    .o_ack    (o_ack)
  );

  hint_decode u_hint1 (
    .i_raw  (step.hint1),
    .o_hint (hint1)
  );

  // No supported instruction reads hint 2.
  hint_decode u_hint2 (
    .i_raw  (step.hint2),
    .o_hint ()
  );

  instr_decode u_decode (
    .i_step  (step),
    .i_hint1 (hint1),
    .o_uop   (uop),
    .o_fault (dec_fault)
  );

  alu_execute u_execute (
    .i_pre  (step.pre),
    .i_uop  (uop),
    .o_post (post)
  );

  reg_writeback u_writeback (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_commit (commit),
    .i_pre    (step.pre),
    .i_post   (post),
    .i_fault  (dec_fault),
    .o_state  (o_state),
    .o_fault  (o_fault)
  );

endmodule

`default_nettype wire

/* design/trace_pkg.sv */
`default_nettype none

package trace_pkg;

  localparam int INSTR_BYTES = 12;

  // Opcode bytes of the supported subset.
  localparam logic [7:0] OPC_NOP    = 8'h90;
  localparam logic [7:0] OPC_INC    = 8'h40;
  localparam logic [7:0] OPC_DEC    = 8'h48;
  localparam logic [7:0] OPC_ADD    = 8'h01;
  localparam logic [7:0] OPC_SUB    = 8'h29;
  localparam logic [7:0] OPC_XOR    = 8'h31;
  localparam logic [7:0] OPC_MOV_ST = 8'h89;
  localparam logic [7:0] OPC_MOV_LD = 8'h8B;
  localparam logic [7:0] OPC_JMP    = 8'hEB;
  localparam logic [7:0] OPC_JCXZ   = 8'hE3;

  // Modrm mod field values.
  localparam logic [1:0] MOD_IND = 2'b00;
  localparam logic [1:0] MOD_REG = 2'b11;

  // Hint access sizes.
  localparam logic [1:0] MASK_BYTE  = 2'd0;
  localparam logic [1:0] MASK_WORD  = 2'd1;
  localparam logic [1:0] MASK_DWORD = 2'd2;

  // Raw hint as the tracer emits it, 72 bits.
  typedef struct packed {
    logic        valid;
    logic        is_write;
    logic [1:0]  mask;
    logic [3:0]  reserved;
    logic [31:0] address;
    logic [31:0] data;
  } raw_hint_t;

  typedef struct packed {
    logic        valid;
    logic        is_write;
    logic [3:0]  byte_en;
    logic [31:0] address;
    logic [31:0] data;
  } hint_t;

  // instr[0] is the first instruction byte.
  typedef struct packed {
    x86_arch_pkg::arch_state_t   pre;
    logic [INSTR_BYTES-1:0][7:0] instr;
    raw_hint_t                   hint1;
    raw_hint_t                   hint2;
  } trace_step_t;

  typedef enum logic [3:0] {
    NOP, INC, DEC, ADD, SUB, XOR, MOV, LOAD, STORE, JMP, JCXZ
  } opcode_e;

  typedef struct packed {
    opcode_e                op;
    x86_arch_pkg::reg_idx_t dst;
    logic [31:0]            a_val;
    logic [31:0]            b_val;
    logic                   write_dst;
    logic [3:0]             len;
    logic [31:0]            rel;
  } uop_t;

  typedef struct packed {
    logic bad_opcode;
    logic bad_hint;
  } fault_t;

endpackage

`default_nettype wire

/* design/x86_arch_pkg.sv */
`default_nettype none

package x86_arch_pkg;

  localparam int NUM_GPR = 8;

  typedef logic [2:0] reg_idx_t;

  // Register indices, in the order modrm encodes them.
  localparam reg_idx_t REG_EAX = 3'd0;
  localparam reg_idx_t REG_ECX = 3'd1;
  localparam reg_idx_t REG_EDX = 3'd2;
  localparam reg_idx_t REG_EBX = 3'd3;
  localparam reg_idx_t REG_ESP = 3'd4;
  localparam reg_idx_t REG_EBP = 3'd5;
  localparam reg_idx_t REG_ESI = 3'd6;
  localparam reg_idx_t REG_EDI = 3'd7;

  // Bit positions of the tracked flags in eflags.
  localparam int FLAG_CF = 0;
  localparam int FLAG_ZF = 6;
  localparam int FLAG_SF = 7;
  localparam int FLAG_OF = 11;

  // Architectural state, 320 bits. gpr[0] is eax.
  typedef struct packed {
    logic [NUM_GPR-1:0][31:0] gpr;
    logic [31:0]              eip;
    logic [31:0]              eflags;
  } arch_state_t;

endpackage

`default_nettype wire

/* verification/clock_gen.sv */
`timescale 1ns/1ns
`default_nettype none

module clock_gen (
  output logic o_clk
);

  localparam int HALF_PERIOD = 10;

  // Free-running 20 ns clock, low at time zero.
  initial begin
    o_clk = 1'b0;
    forever #HALF_PERIOD o_clk = ~o_clk;
  end

endmodule

`default_nettype wire

/* verification/tb_tiny86.sv */
`timescale 1ns/1ns
`default_nettype none

module tb_tiny86;

  localparam int ACK_TIMEOUT = 20;

  typedef struct packed {
    x86_arch_pkg::arch_state_t state;
    trace_pkg::fault_t         fault;
  } expect_t;

  logic                      clk;
  logic                      rst_n;
  logic                      req;
  trace_pkg::trace_step_t    step;
  logic                      ack;
  x86_arch_pkg::arch_state_t state;
  trace_pkg::fault_t         fault;

  // Expected results in issue order, popped when o_ack rises.
  expect_t                   exp_q[$];
  string                     name_q[$];
  expect_t                   exp_cur;
  string                     name_cur;
  logic                      ack_d = 1'b0;

  clock_gen u_clock (.o_clk(clk));

  tiny86 i_dut (
    .i_clk   (clk),
    .i_rst_n (rst_n),
    .i_req   (req),
    .i_step  (step),
    .o_ack   (ack),
    .o_state (state),
    .o_fault (fault)
  );

  task automatic fail_run();
    $display("Finished with errors");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      $display("MISMATCH %s expected %08h actual %08h", name, expected, actual);
      fail_run();
    end
  endtask

  task automatic compare_state(input string name, input x86_arch_pkg::arch_state_t expected,
                               input x86_arch_pkg::arch_state_t actual);
    for (int i = 0; i < x86_arch_pkg::NUM_GPR; i++) begin
      check_value($sformatf("%s gpr%0d", name, i), expected.gpr[3'(i)], actual.gpr[3'(i)]);
    end
    check_value({name, " eip"}, expected.eip, actual.eip);
    check_value({name, " eflags"}, expected.eflags, actual.eflags);
  endtask

  // Reference model of one step, written from the instruction rules.
  function automatic expect_t model_step(input trace_pkg::trace_step_t s);
    expect_t     e;
    logic [7:0]  opc;
    logic [7:0]  modrm;
    logic [2:0]  rm;
    logic [2:0]  rg;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic [31:0] fl;
    logic [31:0] len;
    logic [31:0] rel;
    logic [32:0] sum;
    logic        mem_ok;
    logic        full;
    logic        arith;
    logic        jump;
    opc     = s.instr[0];
    modrm   = s.instr[1];
    rm      = modrm[2:0];
    rg      = modrm[5:3];
    a       = s.pre.gpr[rm];
    b       = s.pre.gpr[rg];
    r       = 32'd0;
    fl      = s.pre.eflags;
    len     = 32'd2;
    rel     = {{24{modrm[7]}}, modrm};
    arith   = 1'b0;
    jump    = 1'b0;
    e.state = s.pre;
    e.fault = '0;
    mem_ok  = (modrm[7:6] == 2'b00) && (rm != 3'd4) && (rm != 3'd5);
    full    = s.hint1.valid && (s.hint1.reserved == 4'd0) && (s.hint1.mask == 2'd2);
    case (opc)
      8'h90: len = 32'd1;
      8'h01, 8'h29, 8'h31: begin
        e.fault.bad_opcode = (modrm[7:6] != 2'b11);
        arith = 1'b1;
        if (opc == 8'h01) begin
          sum = {a[31], a} + {b[31], b};
          r   = a + b;
          fl[x86_arch_pkg::FLAG_CF] = r < a;
          fl[x86_arch_pkg::FLAG_OF] = sum[32] ^ sum[31];
        end else if (opc == 8'h29) begin
          sum = {a[31], a} - {b[31], b};
          r   = a - b;
          fl[x86_arch_pkg::FLAG_CF] = a < b;
          fl[x86_arch_pkg::FLAG_OF] = sum[32] ^ sum[31];
        end else begin
          r = a ^ b;
          fl[x86_arch_pkg::FLAG_CF] = 1'b0;
          fl[x86_arch_pkg::FLAG_OF] = 1'b0;
        end
        e.state.gpr[rm] = r;
      end
      8'h89: begin
        if (modrm[7:6] == 2'b11) begin
          e.state.gpr[rm] = b;
        end else if (mem_ok) begin
          e.fault.bad_hint = !(full && s.hint1.is_write && (s.hint1.address == a) &&
                               (s.hint1.data == b));
        end else begin
          e.fault.bad_opcode = 1'b1;
        end
      end
      8'h8B: begin
        if (mem_ok) begin
          e.fault.bad_hint = !(full && !s.hint1.is_write && (s.hint1.address == a));
          e.state.gpr[rg]  = s.hint1.data;
        end else begin
          e.fault.bad_opcode = 1'b1;
        end
      end
      8'hEB: jump = 1'b1;
      8'hE3: jump = (s.pre.gpr[1] == 32'd0);
      default: begin
        len = 32'd1;
        if (opc[7:4] == 4'h4) begin
          // Bit 3 picks dec over inc.
          arith = 1'b1;
          a     = s.pre.gpr[opc[2:0]];
          r     = opc[3] ? a - 32'd1 : a + 32'd1;
          fl[x86_arch_pkg::FLAG_OF] = opc[3] ? (a[31] && !r[31]) : (!a[31] && r[31]);
          e.state.gpr[opc[2:0]] = r;
        end else begin
          e.fault.bad_opcode = 1'b1;
        end
      end
    endcase
    if (arith) begin
      fl[x86_arch_pkg::FLAG_ZF] = (r == 32'd0);
      fl[x86_arch_pkg::FLAG_SF] = r[31];
    end
    e.state.eflags = fl;
    e.state.eip    = s.pre.eip + len + (jump ? rel : 32'd0);
    if (e.fault.bad_opcode || e.fault.bad_hint) begin
      e.state = s.pre;
    end
    return e;
  endfunction

  // Operand values lean toward the carry and overflow corners.
  function automatic logic [31:0] pick_value();
    case ($urandom_range(0, 7))
      0: return 32'd0;
      1: return 32'd1;
      2: return 32'h7FFF_FFFF;
      3: return 32'h8000_0000;
      4: return 32'hFFFF_FFFF;
      default: return $urandom;
    endcase
  endfunction

  function automatic trace_pkg::trace_step_t random_step();
    trace_pkg::trace_step_t s;
    for (int i = 0; i < x86_arch_pkg::NUM_GPR; i++) begin
      s.pre.gpr[3'(i)] = pick_value();
    end
    for (int i = 0; i < trace_pkg::INSTR_BYTES; i++) begin
      s.instr[4'(i)] = 8'($urandom);
    end
    s.pre.eip    = $urandom;
    s.pre.eflags = $urandom;
    s.hint1      = '0;
    s.hint2      = {8'($urandom), $urandom, $urandom};
    return s;
  endfunction

  function automatic trace_pkg::trace_step_t reg_step(input logic [7:0] opc,
      input logic [7:0] modrm, input logic [31:0] eax_val, input logic [31:0] ecx_val);
    trace_pkg::trace_step_t s;
    s            = random_step();
    s.instr[0]   = opc;
    s.instr[1]   = modrm;
    s.pre.gpr[0] = eax_val;
    s.pre.gpr[1] = ecx_val;
    return s;
  endfunction

  // Load or store through [reg] with a matching full-width hint 1.
  function automatic trace_pkg::trace_step_t mem_step(input logic is_store);
    trace_pkg::trace_step_t s;
    logic [2:0]             rm;
    logic [2:0]             rg;
    s  = random_step();
    rm = 3'($urandom_range(0, 5));
    rg = 3'($urandom);
    if (rm >= 3'd4) begin
      rm = rm + 3'd2;
    end
    s.instr[0]       = is_store ? 8'h89 : 8'h8B;
    s.instr[1]       = {2'b00, rg, rm};
    s.hint1.valid    = 1'b1;
    s.hint1.is_write = is_store;
    s.hint1.mask     = 2'd2;
    s.hint1.address  = s.pre.gpr[rm];
    s.hint1.data     = is_store ? s.pre.gpr[rg] : $urandom;
    return s;
  endfunction

  task automatic run_step(input string name, input trace_pkg::trace_step_t s, input int hold);
    x86_arch_pkg::arch_state_t held;
    int                        n;
    exp_q.push_back(model_step(s));
    name_q.push_back(name);
    if (ack !== 1'b0) begin
      $display("o_ack was high before the request of %s", name);
      fail_run();
    end
    step = s;
    req  = 1'b1;
    n    = 0;
    while (ack !== 1'b1) begin
      @(negedge clk);
      n++;
      if (n > ACK_TIMEOUT) begin
        $display("Timeout waiting for o_ack to rise in %s", name);
        fail_run();
      end
    end
    held = state;
    // Offer a different step while req stays up. It must not be taken.
    step.pre.eip = ~s.pre.eip;
    repeat (hold) begin
      @(negedge clk);
      if (ack !== 1'b1) begin
        $display("o_ack fell while i_req was still high in %s", name);
        fail_run();
      end
      compare_state({name, " hold"}, held, state);
    end
    req = 1'b0;
    n   = 0;
    while (ack !== 1'b0) begin
      @(negedge clk);
      n++;
      if (n > ACK_TIMEOUT) begin
        $display("Timeout waiting for o_ack to fall in %s", name);
        fail_run();
      end
    end
    if (hold > 0) begin
      repeat (2) @(negedge clk);
      compare_state({name, " after release"}, held, state);
    end
  endtask

  // Compare the committed state at each rising o_ack.
  always @(negedge clk) begin
    if (ack === 1'b1 && ack_d !== 1'b1) begin
      if (exp_q.size() == 0) begin
        $display("o_ack rose with no step in flight");
        fail_run();
      end else begin
        exp_cur  = exp_q.pop_front();
        name_cur = name_q.pop_front();
        compare_state(name_cur, exp_cur.state, state);
        check_value({name_cur, " fault"}, {30'd0, exp_cur.fault}, {30'd0, fault});
      end
    end
    ack_d = ack;
  end

  initial begin
    trace_pkg::trace_step_t s;
    int                     k;
    void'($urandom(32'he563));
    rst_n = 1'b0;
    req   = 1'b0;
    step  = '0;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("reset ack", 32'd0, {31'd0, ack});
    check_value("reset fault", 32'd0, {30'd0, fault});
    compare_state("reset", '0, state);

    run_step("add overflow", reg_step(8'h01, 8'hC8, 32'h7FFF_FFFF, 32'd1), 0);
    run_step("add carry", reg_step(8'h01, 8'hC8, 32'hFFFF_FFFF, 32'd1), 0);
    run_step("sub borrow", reg_step(8'h29, 8'hC8, 32'd0, 32'd1), 0);
    run_step("sub overflow", reg_step(8'h29, 8'hC8, 32'h8000_0000, 32'd1), 0);
    run_step("inc overflow", reg_step(8'h40, 8'h00, 32'h7FFF_FFFF, 32'd0), 0);
    run_step("dec overflow", reg_step(8'h48, 8'h00, 32'h8000_0000, 32'd0), 0);
    run_step("xor self", reg_step(8'h31, 8'hC0, 32'h1234_5678, 32'd0), 0);
    for (int n = 0; n < 40; n++) begin
      s = random_step();
      k = $urandom_range(0, 4);
      case (k)
        0: s.instr[0] = 8'h01;
        1: s.instr[0] = 8'h29;
        2: s.instr[0] = 8'h31;
        3: s.instr[0] = 8'h40 | 8'($urandom_range(0, 7));
        default: s.instr[0] = 8'h48 | 8'($urandom_range(0, 7));
      endcase
      s.instr[1] = {2'b11, 6'($urandom)};
      run_step($sformatf("alu %0d", n), s, 0);
    end

    for (int n = 0; n < 10; n++) begin
      s = reg_step(8'h89, {2'b11, 6'($urandom)}, $urandom, $urandom);
      run_step($sformatf("mov reg %0d", n), s, 0);
      run_step($sformatf("load %0d", n), mem_step(1'b0), 0);
      run_step($sformatf("store %0d", n), mem_step(1'b1), 0);
    end

    run_step("nop", reg_step(8'h90, 8'h00, 32'd0, 32'd0), 0);
    run_step("jmp forward", reg_step(8'hEB, 8'h10, 32'd0, 32'd0), 0);
    run_step("jmp back", reg_step(8'hEB, 8'hF0, 32'd0, 32'd0), 0);
    run_step("jcxz taken", reg_step(8'hE3, 8'h7F, 32'd3, 32'd0), 0);
    run_step("jcxz not taken", reg_step(8'hE3, 8'h80, 32'd3, 32'd5), 0);

    run_step("bad opcode 0f", reg_step(8'h0F, 8'h41, 32'd0, 32'd0), 0);
    run_step("bad opcode c3", reg_step(8'hC3, 8'h41, 32'd0, 32'd0), 0);
    run_step("load reg form", reg_step(8'h8B, 8'hC1, 32'd0, 32'd0), 0);
    run_step("add mem form", reg_step(8'h01, 8'h41, 32'd0, 32'd0), 0);
    s = mem_step(1'b1);
    s.hint1.address = s.hint1.address ^ 32'd4;
    run_step("store bad address", s, 0);
    s = mem_step(1'b1);
    s.hint1.data = ~s.hint1.data;
    run_step("store bad data", s, 0);
    s = mem_step(1'b1);
    s.hint1.is_write = 1'b0;
    run_step("store bad direction", s, 0);

    for (int n = 0; n < 6; n++) begin
      run_step($sformatf("hold %0d", n), mem_step(1'b1), $urandom_range(1, 8));
    end

    if (exp_q.size() != 0) begin
      $display("Steps were issued that never got an ack");
      fail_run();
    end else begin
      $display("Finished with no errors");
      $finish;
    end
  end

endmodule

`default_nettype wire
